/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = io_control_tb
FILELIST  = io_control.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# The run passes only if the pass message shows up in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "Simulation PASSED" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* hdl/io_control.sv */
`timescale 1ns/10ps
`include "io_defines.svh"

module io_control #(
	parameter int CPU_CLOCK_FREQ = `DEFAULT_CPU_CLOCK_FREQ,
	parameter int BAUD_RATE      = `DEFAULT_BAUD_RATE
) (
	input  logic                 clk,
	input  logic                 cpu_rst,
	input  io_map_pkg::io_adr_t  adr,
	input  logic                 iowea,
	input  logic                 iorea,
	input  logic [3:0]           wea,
	input  io_map_pkg::io_word_t din_io,
	input  logic                 instr_stop,
	input  logic                 uart_serial_in,
	output io_map_pkg::io_word_t dout_io,
	output logic                 uart_serial_out
);
	import io_map_pkg::*;
	import uart_pkg::*;

	logic       tx_start;
	uart_byte_t tx_data;
	logic       tx_ready;
	logic       rx_pop;
	logic       rx_valid;
	uart_byte_t rx_data;
	logic       cnt_clear;
	io_word_t   cycle_cnt;
	io_word_t   instr_cnt;
	io_word_t   ctrl_word;
	io_word_t   rx_word;
	io_word_t   rd_word;

	// -------------------------------------------------------------------
	// Strobe decode
	// -------------------------------------------------------------------
	assign tx_start  = iowea && (adr == ADR_UART_TX);  // Dropped inside the UART when busy
	assign tx_data   = din_io[7:0];
	assign rx_pop    = iorea && (adr == ADR_UART_RX);
	assign cnt_clear = iowea && (adr == ADR_CNT_CLEAR) && (wea != 4'b0000);

	// -------------------------------------------------------------------
	// Read path
	// -------------------------------------------------------------------
	assign ctrl_word = {{(`XLEN-2){1'b0}}, rx_valid, tx_ready};
	assign rx_word   = rx_valid ? {{(`XLEN-8){1'b0}}, rx_data} : '0;

	always_comb begin
		case (adr)
			ADR_UART_CTRL: rd_word = ctrl_word;
			ADR_UART_RX:   rd_word = rx_word;
			ADR_CYCLE_CNT: rd_word = cycle_cnt;
			ADR_INSTR_CNT: rd_word = instr_cnt;
			default:       rd_word = '0;  // Unmapped and write-only addresses
		endcase
	end

	// The pop lands on this same edge, so the byte is captured before it leaves
	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			dout_io <= '0;
		end else begin
			dout_io <= rd_word;
		end
	end

	// -------------------------------------------------------------------
	// Peripherals
	// -------------------------------------------------------------------
	uart_transmitter #(
		.CPU_CLOCK_FREQ(CPU_CLOCK_FREQ),
		.BAUD_RATE     (BAUD_RATE)
	) u_tx (
		.clk       (clk),
		.cpu_rst   (cpu_rst),
		.tx_start  (tx_start),
		.tx_data   (tx_data),
		.tx_ready  (tx_ready),
		.serial_out(uart_serial_out)
	);

	uart_receiver #(
		.CPU_CLOCK_FREQ(CPU_CLOCK_FREQ),
		.BAUD_RATE     (BAUD_RATE)
	) u_rx (
		.clk      (clk),
		.cpu_rst  (cpu_rst),
		.serial_in(uart_serial_in),
		.rx_pop   (rx_pop),
		.rx_valid (rx_valid),
		.rx_data  (rx_data)
	);

	perf_counters u_cnt (
		.clk       (clk),
		.cpu_rst   (cpu_rst),
		.cnt_clear (cnt_clear),
		.instr_stop(instr_stop),
		.cycle_cnt (cycle_cnt),
		.instr_cnt (instr_cnt)
	);

	// The core issues at most one I/O access per cycle
	a_no_rw_overlap: assert property (@(posedge clk) disable iff (cpu_rst)
		!(iowea && iorea));

endmodule

/* hdl/io_defines.svh */
`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// Data word width of the core
`define XLEN 32

// Width of the I/O address window seen by the CPU
`define IO_MAP_WIDTH 5

`define DEFAULT_CPU_CLOCK_FREQ 50_000_000
`define DEFAULT_BAUD_RATE      115_200

`endif

/* hdl/io_map_pkg.sv */
`include "io_defines.svh"

package io_map_pkg;

	typedef logic [`IO_MAP_WIDTH-1:0] io_adr_t;
	typedef logic [`XLEN-1:0]         io_word_t;

	// -------------------------------------------------------------------
	// Register map of the I/O window
	// -------------------------------------------------------------------
	localparam io_adr_t ADR_UART_CTRL = io_adr_t'(0);  // Bit1 rx_valid, bit0 tx_ready
	localparam io_adr_t ADR_UART_RX   = io_adr_t'(1);  // Reading pops the held byte
	localparam io_adr_t ADR_UART_TX   = io_adr_t'(2);
	localparam io_adr_t ADR_CYCLE_CNT = io_adr_t'(4);
	localparam io_adr_t ADR_INSTR_CNT = io_adr_t'(5);
	localparam io_adr_t ADR_CNT_CLEAR = io_adr_t'(6);  // Needs at least one byte enable

endpackage

/* hdl/perf_counters.sv */
`timescale 1ns/10ps

module perf_counters (
	input  logic                 clk,
	input  logic                 cpu_rst,
	input  logic                 cnt_clear,
	input  logic                 instr_stop,
	output io_map_pkg::io_word_t cycle_cnt,
	output io_map_pkg::io_word_t instr_cnt
);
	import io_map_pkg::*;

	logic cnt_rst;

	assign cnt_rst = cpu_rst | cnt_clear;  // A store to the clear address acts like a reset

	always_ff @(posedge clk) begin
		if (cnt_rst) begin
			cycle_cnt <= '0;
			instr_cnt <= '0;
		end else begin
			cycle_cnt <= cycle_cnt + io_word_t'(1);
			if (!instr_stop) begin
				instr_cnt <= instr_cnt + io_word_t'(1);  // Stalls and bubbles do not retire
			end
		end
	end

	// Both start at zero together, so retired work can never outrun time
	a_instr_le_cycle: assert property (@(posedge clk) disable iff (cpu_rst)
		instr_cnt <= cycle_cnt);

endmodule

/* hdl/uart_pkg.sv */
package uart_pkg;

	typedef logic [7:0] uart_byte_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	// Same phases as the transmitter, prefixed so both can share one scope
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage

/* hdl/uart_receiver.sv */
`timescale 1ns/10ps
`include "io_defines.svh"

module uart_receiver #(
	parameter int CPU_CLOCK_FREQ = `DEFAULT_CPU_CLOCK_FREQ,
	parameter int BAUD_RATE      = `DEFAULT_BAUD_RATE
) (
	input  logic                 clk,
	input  logic                 cpu_rst,
	input  logic                 serial_in,
	input  logic                 rx_pop,
	output logic                 rx_valid,
	output uart_pkg::uart_byte_t rx_data
);
	import uart_pkg::*;

	localparam int CLKS_PER_BIT = CPU_CLOCK_FREQ / BAUD_RATE;
	localparam int HALF_BIT     = CLKS_PER_BIT / 2;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);

	rx_state_t        state;
	logic [1:0]       sync_q;
	logic             line;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_idx;
	uart_byte_t       shift_q;
	logic             bit_done;
	logic             half_done;
	logic             cnt_restart;
	logic             byte_done;
	logic             load;

	// -------------------------------------------------------------------
	// Line synchronizer, idles high like the line itself
	// -------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			sync_q <= 2'b11;
		end else begin
			sync_q <= {sync_q[0], serial_in};
		end
	end

	assign line = sync_q[1];

	// -------------------------------------------------------------------
	// Frame FSM
	// -------------------------------------------------------------------
	assign bit_done    = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign half_done   = (baud_cnt == CNT_W'(HALF_BIT - 1));
	assign cnt_restart = (state == RX_IDLE) || ((state == RX_START) ? half_done : bit_done);
	assign byte_done   = (state == RX_STOP) && bit_done && line;  // Stop bit must be high
	assign load        = byte_done && (!rx_valid || rx_pop);      // Otherwise the new byte is lost

	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			baud_cnt <= cnt_restart ? '0 : baud_cnt + CNT_W'(1);
			case (state)
				RX_IDLE: begin
					if (!line) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (half_done) begin
						state   <= line ? RX_IDLE : RX_DATA;  // A glitch goes back to idle
						bit_idx <= '0;
					end
				end
				RX_DATA: begin
					if (bit_done) begin
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end else begin
							bit_idx <= bit_idx + 3'd1;
						end
					end
				end
				RX_STOP: begin
					if (bit_done) begin
						state <= RX_IDLE;  // Back at mid stop bit to catch the next start
					end
				end
				default: state <= RX_IDLE;
			endcase
			if (load) begin
				rx_valid <= 1'b1;
			end else if (rx_pop) begin
				rx_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_done) begin
			shift_q <= {line, shift_q[7:1]};
		end
		if (load) begin
			rx_data <= shift_q;
		end
	end

	a_hold_until_pop: assert property (@(posedge clk) disable iff (cpu_rst)
		rx_valid && !rx_pop |=> $stable(rx_data));

endmodule

/* hdl/uart_transmitter.sv */
`timescale 1ns/10ps
`include "io_defines.svh"

module uart_transmitter #(
	parameter int CPU_CLOCK_FREQ = `DEFAULT_CPU_CLOCK_FREQ,
	parameter int BAUD_RATE      = `DEFAULT_BAUD_RATE
) (
	input  logic                 clk,
	input  logic                 cpu_rst,
	input  logic                 tx_start,
	input  uart_pkg::uart_byte_t tx_data,
	output logic                 tx_ready,
	output logic                 serial_out
);
	import uart_pkg::*;

	localparam int CLKS_PER_BIT = CPU_CLOCK_FREQ / BAUD_RATE;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);

	tx_state_t        state;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_idx;
	uart_byte_t       shift_q;
	logic             bit_done;

	assign bit_done = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign tx_ready = (state == TX_IDLE);

	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			state      <= TX_IDLE;
			baud_cnt   <= '0;
			bit_idx    <= '0;
			serial_out <= 1'b1;
		end else begin
			baud_cnt <= (state == TX_IDLE || bit_done) ? '0 : baud_cnt + CNT_W'(1);
			case (state)
				TX_IDLE: begin
					if (tx_start) begin
						state      <= TX_START;
						serial_out <= 1'b0;  // Start bit begins right after the strobe
					end
				end
				TX_START: begin
					if (bit_done) begin
						state      <= TX_DATA;
						bit_idx    <= '0;
						serial_out <= shift_q[0];
					end
				end
				TX_DATA: begin
					if (bit_done) begin
						if (bit_idx == 3'd7) begin
							state      <= TX_STOP;
							serial_out <= 1'b1;
						end else begin
							bit_idx    <= bit_idx + 3'd1;
							serial_out <= shift_q[0];
						end
					end
				end
				TX_STOP: begin
					if (bit_done) begin
						state <= TX_IDLE;  // Ready again as the stop bit ends
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == TX_IDLE && tx_start) begin
			shift_q <= tx_data;
		end else if (bit_done && (state == TX_START || state == TX_DATA)) begin
			shift_q <= shift_q >> 1;  // LSB first
		end
	end

	a_idle_line_high: assert property (@(posedge clk) disable iff (cpu_rst)
		state == TX_IDLE |-> serial_out);

endmodule

/* io_control.f */
+incdir+hdl
+incdir+tests
hdl/io_map_pkg.sv
hdl/uart_pkg.sv
hdl/uart_transmitter.sv
hdl/uart_receiver.sv
hdl/perf_counters.sv
hdl/io_control.sv
tests/io_control_tb.sv

/* tests/io_control_tb_tasks.svh */
`ifndef IO_CONTROL_TB_TASKS_SVH
`define IO_CONTROL_TB_TASKS_SVH

// ---------------------------------------------------------------------
// Bus access
// ---------------------------------------------------------------------
task automatic io_write(input io_adr_t a, input io_word_t data, input logic [3:0] be);
	@(posedge clk);
	#1;
	adr    = a;
	din_io = data;
	wea    = be;
	iowea  = 1'b1;
	@(posedge clk);  // DUT takes the strobe on this edge
	#1;
	strobe_edge = cycle_count;
	iowea       = 1'b0;
	wea         = 4'b0000;
endtask

task automatic io_read(input io_adr_t a, input logic pop, output io_word_t data);
	@(posedge clk);
	#1;
	adr   = a;
	iorea = pop;
	@(posedge clk);  // Address sampled and read word registered here
	#1;
	sample_edge = cycle_count;
	iorea       = 1'b0;
	data        = dout_io;
endtask

task automatic wait_tx_ready();
	io_word_t ctrl;
	do begin
		io_read(ADR_UART_CTRL, 1'b0, ctrl);
	end while (!ctrl[0]);
endtask

task automatic wait_rx_valid();
	io_word_t ctrl;
	do begin
		io_read(ADR_UART_CTRL, 1'b0, ctrl);
	end while (!ctrl[1]);
endtask

// Start bit, eight data bits LSB first, stop bit
task automatic send_serial_frame(input uart_byte_t data);
	logic [9:0] frame;
	frame = {1'b1, data, 1'b0};
	for (int i = 0; i < 10; i++) begin
		@(posedge clk);
		#1;
		ext_line = frame[i];
		repeat (BIT_CYCLES - 1) @(posedge clk);
	end
endtask

// ---------------------------------------------------------------------
// Result compares
// ---------------------------------------------------------------------
task automatic check_word(input string name, input io_word_t expected, input io_word_t actual);
	check_count++;
	if (actual !== expected) begin
		$display("error: %s expected %h, got %h", name, expected, actual);
		error_count++;
	end
endtask

task automatic check_byte(input string name, input uart_byte_t expected,
	input uart_byte_t actual);
	check_count++;
	if (actual !== expected) begin
		$display("error: %s expected %h, got %h", name, expected, actual);
		error_count++;
	end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
	check_count++;
	if (actual !== expected) begin
		$display("error: %s expected %h, got %h", name, expected, actual);
		error_count++;
	end
endtask

`endif

/* tests/io_control_tb.sv */
`timescale 1ns/10ps

module io_control_tb;
	import io_map_pkg::*;
	import uart_pkg::*;

	localparam int TB_CLOCK_FREQ  = 1_000_000;
	localparam int TB_BAUD_RATE   = 125_000;
	localparam int BIT_CYCLES     = TB_CLOCK_FREQ / TB_BAUD_RATE;
	localparam int FRAME_CYCLES   = 10 * BIT_CYCLES;
	localparam int TIMEOUT_CYCLES = 50 * FRAME_CYCLES;  // About ten frames of traffic, wide margin
	localparam int STALL_CYCLES   = 5;

	logic       clk = 1'b0;
	logic       cpu_rst;
	io_adr_t    adr;
	logic       iowea;
	logic       iorea;
	logic [3:0] wea;
	io_word_t   din_io;
	logic       instr_stop;
	logic       uart_serial_in;
	io_word_t   dout_io;
	logic       uart_serial_out;
	logic       loopback;
	logic       ext_line;
	integer     seed;
	int         error_count;
	int         check_count;
	int         cycle_count;
	int         strobe_edge;
	int         sample_edge;

	always #4 clk = ~clk;

	assign uart_serial_in = loopback ? uart_serial_out : ext_line;

	io_control #(
		.CPU_CLOCK_FREQ(TB_CLOCK_FREQ),
		.BAUD_RATE     (TB_BAUD_RATE)
	) uut (
		.clk            (clk),
		.cpu_rst        (cpu_rst),
		.adr            (adr),
		.iowea          (iowea),
		.iorea          (iorea),
		.wea            (wea),
		.din_io         (din_io),
		.instr_stop     (instr_stop),
		.uart_serial_in (uart_serial_in),
		.dout_io        (dout_io),
		.uart_serial_out(uart_serial_out)
	);

	`include "io_control_tb_tasks.svh"

	// ---------------------------------------------------------------------
	// Directed tests
	// ---------------------------------------------------------------------
	task automatic after_reset_values();
		io_word_t word;
		check_word("dout_io", '0, dout_io);
		check_bit("uart_serial_out", 1'b1, uart_serial_out);
		io_read(ADR_UART_CTRL, 1'b0, word);
		check_word("dout_io (UART_CTRL)", io_word_t'(1), word);
		io_read(io_adr_t'(3), 1'b0, word);
		check_word("dout_io (adr 3)", '0, word);
		io_read(io_adr_t'(7), 1'b0, word);
		check_word("dout_io (adr 7)", '0, word);
	endtask

	task automatic loopback_bytes();
		io_word_t   word;
		io_word_t   rnd;
		uart_byte_t sent;
		loopback = 1'b1;
		for (int i = 0; i < 3; i++) begin
			rnd  = $random(seed);
			sent = rnd[7:0];
			wait_tx_ready();
			io_write(ADR_UART_TX, {24'h0, sent}, 4'b0001);
			wait_rx_valid();
			io_read(ADR_UART_RX, 1'b1, word);
			check_byte("rx_data", sent, word[7:0]);
			check_word("dout_io (UART_RX)", {24'h0, sent}, word);  // Zero-extended
			io_read(ADR_UART_CTRL, 1'b0, word);
			check_bit("rx_valid", 1'b0, word[1]);
		end
	endtask

	task automatic dropped_tx_write();
		io_word_t   word;
		io_word_t   rnd;
		uart_byte_t first;
		logic       second_seen;
		rnd         = $random(seed);
		first       = rnd[7:0];
		second_seen = 1'b0;
		wait_tx_ready();
		io_write(ADR_UART_TX, {24'h0, first}, 4'b0001);
		io_read(ADR_UART_CTRL, 1'b0, word);
		check_bit("tx_ready", 1'b0, word[0]);
		io_write(ADR_UART_TX, {24'h0, ~first}, 4'b0001);  // Lands while the frame is still going
		wait_rx_valid();
		io_read(ADR_UART_RX, 1'b1, word);
		check_byte("rx_data", first, word[7:0]);
		for (int i = 0; i < FRAME_CYCLES; i++) begin  // Two cycles per read, two frames in all
			io_read(ADR_UART_CTRL, 1'b0, word);
			second_seen = second_seen | word[1];
		end
		check_count++;
		if (second_seen) begin
			$display("A second byte arrived although its write was made while busy");
			error_count++;
		end
	endtask

	task automatic external_frames();
		io_word_t word;
		loopback = 1'b0;
		send_serial_frame(8'hA5);
		wait_rx_valid();
		send_serial_frame(8'h3C);  // No pop yet, so this one must be dropped
		repeat (BIT_CYCLES) @(posedge clk);
		io_read(ADR_UART_CTRL, 1'b0, word);
		check_bit("rx_valid", 1'b1, word[1]);
		io_read(ADR_UART_RX, 1'b1, word);
		check_byte("rx_data", 8'hA5, word[7:0]);
		io_read(ADR_UART_CTRL, 1'b0, word);
		check_bit("rx_valid", 1'b0, word[1]);
	endtask

	task automatic counter_clear();
		io_word_t word;
		int       clear_edge;
		int       k;
		io_write(ADR_CNT_CLEAR, '0, 4'b0001);
		clear_edge = strobe_edge;
		instr_stop = 1'b1;
		repeat (STALL_CYCLES) @(posedge clk);
		#1;
		instr_stop = 1'b0;
		io_read(ADR_CYCLE_CNT, 1'b0, word);
		k = sample_edge - clear_edge;
		check_word("dout_io (CYCLE_CNT)", io_word_t'(k - 1), word);
		io_read(ADR_INSTR_CNT, 1'b0, word);
		k = sample_edge - clear_edge;
		check_word("dout_io (INSTR_CNT)", io_word_t'(k - 1 - STALL_CYCLES), word);
		io_write(ADR_CNT_CLEAR, '0, 4'b0000);  // No byte enable means no clear
		io_read(ADR_CYCLE_CNT, 1'b0, word);
		k = sample_edge - clear_edge;
		check_word("dout_io (CYCLE_CNT)", io_word_t'(k - 1), word);
		io_read(ADR_INSTR_CNT, 1'b0, word);
		k = sample_edge - clear_edge;
		check_word("dout_io (INSTR_CNT)", io_word_t'(k - 1 - STALL_CYCLES), word);
	endtask

	// ---------------------------------------------------------------------
	// Run control
	// ---------------------------------------------------------------------
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count = cycle_count + 1;
		end
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		seed        = 32'hdeec_da92;
		error_count = 0;
		check_count = 0;
		strobe_edge = 0;
		sample_edge = 0;
		cpu_rst     = 1'b1;
		adr         = '0;
		iowea       = 1'b0;
		iorea       = 1'b0;
		wea         = 4'b0000;
		din_io      = '0;
		instr_stop  = 1'b0;
		loopback    = 1'b1;
		ext_line    = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		cpu_rst = 1'b0;
		after_reset_values();
		loopback_bytes();
		dropped_tx_write();
		external_frames();
		counter_clear();
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
